// ==== hdl/lc3b_core.sv ====
`timescale 1ns/1ps

module lc3b_core #(
    parameter int DMEM_WORDS = 16
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               instr_valid,
    input  lc3b_pkg::lc3b_word instr,
    output logic               instr_ready,
    output logic               wb_valid,
    output lc3b_pkg::lc3b_reg  wb_dest,
    output lc3b_pkg::lc3b_word wb_data
);

    lc3b_pkg::lc3b_control_word          id_ex_control;
    lc3b_pkg::lc3b_control_word          ex_mem_control;
    lc3b_pkg::lc3b_control_word          mem_wb_control;
    lc3b_pkg::lc3b_word                  id_ex_sr1_data;
    lc3b_pkg::lc3b_word                  id_ex_sr2_data;
    lc3b_pkg::lc3b_word                  mem_result;
    lc3b_pkg::lc3b_word                  mem_store_data;
    lc3b_pkg::lc3b_word                  load_data;
    lc3b_pkg::lc3b_pipeline_control_word pipe_ctrl;
    lc3b_pkg::lc3b_forward_ID_mux_sel    fwd_id_a;
    lc3b_pkg::lc3b_forward_ID_mux_sel    fwd_id_b;
    lc3b_pkg::lc3b_forward_EX_mux_sel    fwd_ex_a;
    lc3b_pkg::lc3b_forward_EX_mux_sel    fwd_ex_b;

    lc3b_decode u_decode (
        .clk(clk), .arst_n(arst_n),
        .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
        .pipe_ctrl(pipe_ctrl),
        .forward_ID_A_mux_sel(fwd_id_a), .forward_ID_B_mux_sel(fwd_id_b),
        .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data),
        .id_ex_control(id_ex_control),
        .id_ex_sr1_data(id_ex_sr1_data), .id_ex_sr2_data(id_ex_sr2_data)
    );

    lc3b_forwarding_controller u_fwd (
        .barrier_ID_EX_control(id_ex_control),
        .barrier_EX_MEM_control(ex_mem_control),
        .barrier_MEM_WB_control(mem_wb_control),
        .forward_ID_A_mux_sel(fwd_id_a), .forward_ID_B_mux_sel(fwd_id_b),
        .forward_EX_A_mux_sel(fwd_ex_a), .forward_EX_B_mux_sel(fwd_ex_b),
        .pipeline_control_request(pipe_ctrl)
    );

    lc3b_execute #(.DMEM_WORDS(DMEM_WORDS)) u_execute (
        .clk(clk), .arst_n(arst_n),
        .id_ex_control(id_ex_control),
        .id_ex_sr1_data(id_ex_sr1_data), .id_ex_sr2_data(id_ex_sr2_data),
        .forward_EX_A_mux_sel(fwd_ex_a), .forward_EX_B_mux_sel(fwd_ex_b),
        .barrier_EX_MEM_reset(pipe_ctrl.barrier_EX_MEM_reset),
        .wb_data(wb_data),
        .ex_mem_control(ex_mem_control),
        .mem_result(mem_result), .mem_store_data(mem_store_data)
    );

    lc3b_memory #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
        .clk(clk), .arst_n(arst_n),
        .ex_mem_control(ex_mem_control),
        .mem_result(mem_result), .mem_store_data(mem_store_data),
        .load_data(load_data)
    );

    lc3b_result u_result (
        .clk(clk), .arst_n(arst_n),
        .ex_mem_control(ex_mem_control),
        .mem_result(mem_result), .load_data(load_data),
        .mem_wb_control(mem_wb_control),
        .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data)
    );

endmodule

// ==== hdl/lc3b_decode.sv ====
`timescale 1ns/1ps

module lc3b_decode (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               instr_valid,
    input  lc3b_pkg::lc3b_word                 instr,
    output logic                               instr_ready,
    input  lc3b_pkg::lc3b_pipeline_control_word pipe_ctrl,
    input  lc3b_pkg::lc3b_forward_ID_mux_sel   forward_ID_A_mux_sel,
    input  lc3b_pkg::lc3b_forward_ID_mux_sel   forward_ID_B_mux_sel,
    input  logic                               wb_valid,
    input  lc3b_pkg::lc3b_reg                  wb_dest,
    input  lc3b_pkg::lc3b_word                 wb_data,
    output lc3b_pkg::lc3b_control_word         id_ex_control,
    output lc3b_pkg::lc3b_word                 id_ex_sr1_data,
    output lc3b_pkg::lc3b_word                 id_ex_sr2_data
);

    lc3b_pkg::lc3b_word         regs [8];
    lc3b_pkg::lc3b_control_word ctrl_d;
    lc3b_pkg::lc3b_word         sr1_d;
    lc3b_pkg::lc3b_word         sr2_d;
    logic                       accept;
    logic                       hold;

    // write-first read
    function automatic lc3b_pkg::lc3b_word rf_read(lc3b_pkg::lc3b_reg idx);
        rf_read = (wb_valid && wb_dest == idx) ? wb_data : regs[idx];
    endfunction

    assign instr_ready = ~pipe_ctrl.barrier_IF_ID_stall;
    assign accept      = instr_valid & instr_ready;
    assign hold        = pipe_ctrl.active & pipe_ctrl.barrier_ID_EX_stall;

    always_comb begin
        ctrl_d             = '0;
        ctrl_d.opcode      = lc3b_pkg::lc3b_opcode'(instr[15:12]);
        ctrl_d.regfile_dest = instr[11:9];
        ctrl_d.regfile_sr1 = instr[8:6];
        ctrl_d.regfile_sr2 = instr[2:0];
        ctrl_d.imm         = {{11{instr[4]}}, instr[4:0]}; // imm5
        case (ctrl_d.opcode)
            lc3b_pkg::op_add, lc3b_pkg::op_and: begin
                ctrl_d.regfile_load = 1'b1;
                ctrl_d.requires_sr1 = 1'b1;
                ctrl_d.requires_sr2 = ~instr[5];
                ctrl_d.use_imm      = instr[5];
                ctrl_d.alu_op = (ctrl_d.opcode == lc3b_pkg::op_add) ?
                                lc3b_pkg::alu_add : lc3b_pkg::alu_and;
            end
            lc3b_pkg::op_not: begin
                ctrl_d.regfile_load = 1'b1;
                ctrl_d.requires_sr1 = 1'b1;
                ctrl_d.alu_op       = lc3b_pkg::alu_not;
            end
            lc3b_pkg::op_ldr, lc3b_pkg::op_str: begin
                ctrl_d.imm                = {{10{instr[5]}}, instr[5:0]}; // offset6
                ctrl_d.requires_sr1       = 1'b1;
                ctrl_d.data_memory_access = 1'b1;
                if (ctrl_d.opcode == lc3b_pkg::op_str) begin
                    ctrl_d.regfile_sr2              = instr[11:9];
                    ctrl_d.requires_sr2             = 1'b1;
                    ctrl_d.alu_op                   = lc3b_pkg::alu_pass_b;
                    ctrl_d.data_memory_write_enable = 1'b1;
                end else begin
                    ctrl_d.regfile_load = 1'b1;
                    ctrl_d.use_imm      = 1'b1;
                end
            end
            lc3b_pkg::op_br: ; // no-op
            default: ;
        endcase
    end

    always_comb begin
        sr1_d = (forward_ID_A_mux_sel == lc3b_pkg::lc3b_forward_ID_mux_sel_stage_WB_regfile_data)
                ? wb_data : rf_read(ctrl_d.regfile_sr1);
        sr2_d = (forward_ID_B_mux_sel == lc3b_pkg::lc3b_forward_ID_mux_sel_stage_WB_regfile_data)
                ? wb_data : rf_read(ctrl_d.regfile_sr2);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_dest] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex_control <= '0;
        end else if (!hold) begin
            id_ex_control <= accept ? ctrl_d : '0; // bubble when idle
        end
    end

    always_ff @(posedge clk) begin
        if (!hold || pipe_ctrl.barrier_ID_EX_force_sr1_load) begin
            id_ex_sr1_data <= sr1_d;
        end
        if (!hold || pipe_ctrl.barrier_ID_EX_force_sr2_load) begin
            id_ex_sr2_data <= sr2_d;
        end
    end

endmodule

// ==== hdl/lc3b_execute.sv ====
`timescale 1ns/1ps

module lc3b_execute #(
    parameter int DMEM_WORDS = 16
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  lc3b_pkg::lc3b_control_word      id_ex_control,
    input  lc3b_pkg::lc3b_word              id_ex_sr1_data,
    input  lc3b_pkg::lc3b_word              id_ex_sr2_data,
    input  lc3b_pkg::lc3b_forward_EX_mux_sel forward_EX_A_mux_sel,
    input  lc3b_pkg::lc3b_forward_EX_mux_sel forward_EX_B_mux_sel,
    input  logic                            barrier_EX_MEM_reset,
    input  lc3b_pkg::lc3b_word              wb_data,
    output lc3b_pkg::lc3b_control_word      ex_mem_control,
    output lc3b_pkg::lc3b_word              mem_result,
    output lc3b_pkg::lc3b_word              mem_store_data
);

    lc3b_pkg::lc3b_word op_a;
    lc3b_pkg::lc3b_word op_b;
    lc3b_pkg::lc3b_word alu_b;
    lc3b_pkg::lc3b_word alu_out;
    lc3b_pkg::lc3b_word addr_sum;
    lc3b_pkg::lc3b_word ex_result;

    function automatic lc3b_pkg::lc3b_word fwd_pick(lc3b_pkg::lc3b_forward_EX_mux_sel sel,
                                                    lc3b_pkg::lc3b_word id_val);
        case (sel)
            lc3b_pkg::lc3b_forward_EX_mux_sel_stage_MEM_regfile_data: fwd_pick = mem_result;
            lc3b_pkg::lc3b_forward_EX_mux_sel_stage_WB_regfile_data:  fwd_pick = wb_data;
            default:                                                  fwd_pick = id_val;
        endcase
    endfunction

    always_comb begin
        op_a = fwd_pick(forward_EX_A_mux_sel, id_ex_sr1_data);
        op_b = fwd_pick(forward_EX_B_mux_sel, id_ex_sr2_data);
    end

    assign alu_b = id_ex_control.use_imm ? id_ex_control.imm : op_b;

    always_comb begin
        case (id_ex_control.alu_op)
            lc3b_pkg::alu_add: alu_out = op_a + alu_b;
            lc3b_pkg::alu_and: alu_out = op_a & alu_b;
            lc3b_pkg::alu_not: alu_out = ~op_a;
            default:           alu_out = alu_b; // STR source
        endcase
    end

    assign addr_sum  = op_a + id_ex_control.imm;
    assign ex_result = id_ex_control.data_memory_access ?
                       lc3b_pkg::lc3b_word'(addr_sum % DMEM_WORDS) : alu_out;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem_control <= '0;
        end else begin
            ex_mem_control <= barrier_EX_MEM_reset ? '0 : id_ex_control;
        end
    end

    always_ff @(posedge clk) begin
        mem_result     <= ex_result;
        mem_store_data <= alu_out;
    end

endmodule

// ==== hdl/lc3b_forwarding_controller.sv ====
`timescale 1ns/1ps

module lc3b_forwarding_controller (
    input  lc3b_pkg::lc3b_control_word          barrier_ID_EX_control,
    input  lc3b_pkg::lc3b_control_word          barrier_EX_MEM_control,
    input  lc3b_pkg::lc3b_control_word          barrier_MEM_WB_control,
    output lc3b_pkg::lc3b_forward_ID_mux_sel    forward_ID_A_mux_sel,
    output lc3b_pkg::lc3b_forward_ID_mux_sel    forward_ID_B_mux_sel,
    output lc3b_pkg::lc3b_forward_EX_mux_sel    forward_EX_A_mux_sel,
    output lc3b_pkg::lc3b_forward_EX_mux_sel    forward_EX_B_mux_sel,
    output lc3b_pkg::lc3b_pipeline_control_word pipeline_control_request
);

    logic ex_mem_sr1;
    logic ex_mem_sr2;
    logic mem_wb_sr1;
    logic mem_wb_sr2;
    logic ex_mem_is_load;

    assign ex_mem_sr1 = barrier_EX_MEM_control.regfile_load &
                        barrier_ID_EX_control.requires_sr1 &
                        (barrier_ID_EX_control.regfile_sr1 == barrier_EX_MEM_control.regfile_dest);
    assign ex_mem_sr2 = barrier_EX_MEM_control.regfile_load &
                        barrier_ID_EX_control.requires_sr2 &
                        (barrier_ID_EX_control.regfile_sr2 == barrier_EX_MEM_control.regfile_dest);
    assign mem_wb_sr1 = barrier_MEM_WB_control.regfile_load &
                        barrier_ID_EX_control.requires_sr1 &
                        (barrier_ID_EX_control.regfile_sr1 == barrier_MEM_WB_control.regfile_dest);
    assign mem_wb_sr2 = barrier_MEM_WB_control.regfile_load &
                        barrier_ID_EX_control.requires_sr2 &
                        (barrier_ID_EX_control.regfile_sr2 == barrier_MEM_WB_control.regfile_dest);

    assign ex_mem_is_load = barrier_EX_MEM_control.data_memory_access &
                            ~barrier_EX_MEM_control.data_memory_write_enable;

    always_comb begin
        pipeline_control_request = '0;
        forward_ID_A_mux_sel     = lc3b_pkg::lc3b_forward_ID_mux_sel_pass;
        forward_ID_B_mux_sel     = lc3b_pkg::lc3b_forward_ID_mux_sel_pass;
        forward_EX_A_mux_sel     = lc3b_pkg::lc3b_forward_EX_mux_sel_pass;
        forward_EX_B_mux_sel     = lc3b_pkg::lc3b_forward_EX_mux_sel_pass;

        // nearest producer wins
        if (ex_mem_sr1) begin
            forward_EX_A_mux_sel = lc3b_pkg::lc3b_forward_EX_mux_sel_stage_MEM_regfile_data;
        end else if (mem_wb_sr1) begin
            forward_EX_A_mux_sel = lc3b_pkg::lc3b_forward_EX_mux_sel_stage_WB_regfile_data;
        end

        if (ex_mem_sr2) begin
            forward_EX_B_mux_sel = lc3b_pkg::lc3b_forward_EX_mux_sel_stage_MEM_regfile_data;
        end else if (mem_wb_sr2) begin
            forward_EX_B_mux_sel = lc3b_pkg::lc3b_forward_EX_mux_sel_stage_WB_regfile_data;
        end

        // load data not ready until MEM_WB
        if (ex_mem_is_load && (ex_mem_sr1 || ex_mem_sr2)) begin
            pipeline_control_request.active               = 1'b1;
            pipeline_control_request.barrier_IF_ID_stall  = 1'b1;
            pipeline_control_request.barrier_ID_EX_stall  = 1'b1;
            pipeline_control_request.barrier_EX_MEM_reset = 1'b1;

            // retiring value would be lost while ID_EX holds
            if (mem_wb_sr1) begin
                pipeline_control_request.barrier_ID_EX_force_sr1_load = 1'b1;
                forward_ID_A_mux_sel = lc3b_pkg::lc3b_forward_ID_mux_sel_stage_WB_regfile_data;
            end
            if (mem_wb_sr2) begin
                pipeline_control_request.barrier_ID_EX_force_sr2_load = 1'b1;
                forward_ID_B_mux_sel = lc3b_pkg::lc3b_forward_ID_mux_sel_stage_WB_regfile_data;
            end
        end
    end

endmodule

// ==== hdl/lc3b_memory.sv ====
`timescale 1ns/1ps

module lc3b_memory #(
    parameter int DMEM_WORDS = 16
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  lc3b_pkg::lc3b_control_word ex_mem_control,
    input  lc3b_pkg::lc3b_word         mem_result,
    input  lc3b_pkg::lc3b_word         mem_store_data,
    output lc3b_pkg::lc3b_word         load_data
);

    localparam int AW = $clog2(DMEM_WORDS);

    lc3b_pkg::lc3b_word dmem [DMEM_WORDS];
    logic [AW-1:0]      idx;
    logic               wr_en;

    assign idx   = mem_result[AW-1:0]; // already reduced in EX
    assign wr_en = ex_mem_control.data_memory_access & ex_mem_control.data_memory_write_enable;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (wr_en) begin
            dmem[idx] <= mem_store_data;
        end
    end

    assign load_data = dmem[idx];

endmodule

// ==== hdl/lc3b_pkg.sv ====
package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;

    // LC-3b opcode field [15:12], only the supported subset
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add    = 2'd0,
        alu_and    = 2'd1,
        alu_not    = 2'd2,
        alu_pass_b = 2'd3 // store data routing
    } lc3b_alu_op;

    typedef struct packed {
        lc3b_opcode opcode;
        logic       regfile_load;
        lc3b_reg    regfile_dest;
        logic       requires_sr1;
        logic       requires_sr2;
        lc3b_reg    regfile_sr1;
        lc3b_reg    regfile_sr2; // store source on STR
        lc3b_alu_op alu_op;
        logic       use_imm;
        lc3b_word   imm;
        logic       data_memory_access;
        logic       data_memory_write_enable;
    } lc3b_control_word;

    typedef struct packed {
        logic active;
        logic barrier_IF_ID_stall;
        logic barrier_ID_EX_stall;
        logic barrier_EX_MEM_reset;
        logic barrier_ID_EX_force_sr1_load;
        logic barrier_ID_EX_force_sr2_load;
    } lc3b_pipeline_control_word;

    typedef enum logic [1:0] {
        lc3b_forward_EX_mux_sel_pass                  = 2'd0,
        lc3b_forward_EX_mux_sel_stage_MEM_regfile_data = 2'd1,
        lc3b_forward_EX_mux_sel_stage_WB_regfile_data  = 2'd2
    } lc3b_forward_EX_mux_sel;

    typedef enum logic {
        lc3b_forward_ID_mux_sel_pass                 = 1'b0,
        lc3b_forward_ID_mux_sel_stage_WB_regfile_data = 1'b1
    } lc3b_forward_ID_mux_sel;

endpackage

// ==== hdl/lc3b_result.sv ====
`timescale 1ns/1ps

module lc3b_result (
    input  logic                       clk,
    input  logic                       arst_n,
    input  lc3b_pkg::lc3b_control_word ex_mem_control,
    input  lc3b_pkg::lc3b_word         mem_result,
    input  lc3b_pkg::lc3b_word         load_data,
    output lc3b_pkg::lc3b_control_word mem_wb_control,
    output logic                       wb_valid,
    output lc3b_pkg::lc3b_reg          wb_dest,
    output lc3b_pkg::lc3b_word         wb_data
);

    lc3b_pkg::lc3b_word mem_wb_data;
    logic               is_load;

    assign is_load = ex_mem_control.data_memory_access & ~ex_mem_control.data_memory_write_enable;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb_control <= '0;
        end else begin
            mem_wb_control <= ex_mem_control;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb_data <= is_load ? load_data : mem_result;
    end

    assign wb_valid = mem_wb_control.regfile_load;
    assign wb_dest  = mem_wb_control.regfile_dest;
    assign wb_data  = mem_wb_data;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, status follows the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f sim.f --top-module lc3b_core_tb \
    -Mdir obj_dir -o lc3b_core_tb > sim.log 2>&1 &&
    ./obj_dir/lc3b_core_tb >> sim.log 2>&1 ||
    echo "TESTBENCH FAILED: build or run error" >> sim.log
cat sim.log
! grep -q "TESTBENCH FAILED" sim.log

// ==== sim.f ====
+incdir+tests
hdl/lc3b_pkg.sv
hdl/lc3b_decode.sv
hdl/lc3b_forwarding_controller.sv
hdl/lc3b_execute.sv
hdl/lc3b_memory.sv
hdl/lc3b_result.sv
hdl/lc3b_core.sv
tests/lc3b_core_tb.sv

// ==== tests/lc3b_tb_table.svh ====
// instr, gap before the row, writeback expected, dest and value per row
localparam int NUM_ROWS = 22;

localparam tb_row_t ROWS [NUM_ROWS] = '{
    '{16'h1225, 1'b0, 1'b1, 3'd1, 16'h0005}, // add r1, r0, #5
    '{16'h143D, 1'b0, 1'b1, 3'd2, 16'hFFFD}, // add r2, r0, #-3
    '{16'h967F, 1'b0, 1'b1, 3'd3, 16'hFFFA}, // not r3, r1
    '{16'h18C2, 1'b0, 1'b1, 3'd4, 16'hFFF7}, // add r4, r3, r2
    '{16'h5B03, 1'b0, 1'b1, 3'd5, 16'hFFF2}, // and r5, r4, r3
    '{16'h1B61, 1'b0, 1'b1, 3'd5, 16'hFFF3}, // add r5, r5, #1
    '{16'h1D45, 1'b0, 1'b1, 3'd6, 16'hFFE6}, // add r6, r5, r5 with r5 in both stages
    '{16'h1FA2, 1'b1, 1'b1, 3'd7, 16'hFFE8}, // add r7, r6, #2 after idle cycles
    '{16'h1629, 1'b0, 1'b1, 3'd3, 16'h0009}, // add r3, r0, #9
    '{16'h7643, 1'b0, 1'b0, 3'd0, 16'h0000}, // str r3, r1, #3 -> mem[8]
    '{16'h6843, 1'b0, 1'b1, 3'd4, 16'h0009}, // ldr r4, r1, #3
    '{16'h1B02, 1'b0, 1'b1, 3'd5, 16'h0006}, // load-use on r4
    '{16'h1427, 1'b1, 1'b1, 3'd2, 16'h0007}, // add r2, r0, #7
    '{16'h6608, 1'b0, 1'b1, 3'd3, 16'h0009}, // ldr r3, r0, #8
    '{16'h1CC2, 1'b0, 1'b1, 3'd6, 16'h0010}, // add r6, r3, r2 stalls on r3 while r2 retires
    '{16'h7C4F, 1'b0, 1'b0, 3'd0, 16'h0000}, // str r6, r1, #15 wraps to mem[4]
    '{16'h0E00, 1'b0, 1'b0, 3'd0, 16'h0000}, // br
    '{16'h6E14, 1'b0, 1'b1, 3'd7, 16'h0010}, // ldr r7, r0, #20 wraps to mem[4]
    '{16'h91FF, 1'b0, 1'b1, 3'd0, 16'hFFEF}, // not r0, r7
    '{16'h1207, 1'b0, 1'b1, 3'd1, 16'hFFFF}, // add r1, r0, r7
    '{16'h5446, 1'b0, 1'b1, 3'd2, 16'h0010}, // and r2, r1, r6
    '{16'h583E, 1'b0, 1'b1, 3'd4, 16'hFFEE}  // and r4, r0, #-2
};

// ==== tests/lc3b_core_tb.sv ====
`timescale 1ns/1ps

module lc3b_core_tb;

    typedef struct packed {
        logic [15:0] instr;
        logic        gap;
        logic        wb;
        logic [2:0]  dest;
        logic [15:0] value;
    } tb_row_t;

    `include "lc3b_tb_table.svh"

    localparam int WAIT_LIMIT      = 50;
    localparam int STALLS_EXPECTED = 3; // one per load-use pair

    logic               clk;
    logic               arst_n;
    logic               instr_valid;
    lc3b_pkg::lc3b_word instr;
    logic               instr_ready;
    logic               wb_valid;
    lc3b_pkg::lc3b_reg  wb_dest;
    lc3b_pkg::lc3b_word wb_data;

    tb_row_t expected_q [$];
    int      errors;
    int      checks;
    int      stall_cycles;
    bit      timed_out;

    lc3b_core #(.DMEM_WORDS(16)) dut (
        .clk(clk),
        .arst_n(arst_n),
        .instr_valid(instr_valid),
        .instr(instr),
        .instr_ready(instr_ready),
        .wb_valid(wb_valid),
        .wb_dest(wb_dest),
        .wb_data(wb_data)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERR %s got 0x%04h expected 0x%04h at %0t", name, got, want, $time);
        end
    endtask

    // writeback monitor
    always @(posedge clk) begin
        tb_row_t row;
        if (arst_n) begin
            if (!instr_ready) begin
                stall_cycles++;
            end
            if (wb_valid) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("writeback to r%0d with no writeback left to expect", wb_dest);
                end else begin
                    row = expected_q.pop_front();
                    check_value("wb_dest", 16'(wb_dest), 16'(row.dest));
                    check_value("wb_data", wb_data, row.value);
                end
            end
        end
    end

    initial begin
        int gap;
        int waited;
        clk          = 1'b0;
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        errors       = 0;
        checks       = 0;
        stall_cycles = 0;
        timed_out    = 1'b0;
        void'($urandom(32'h1764));
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (ROWS[i].wb) begin
                expected_q.push_back(ROWS[i]);
            end
        end

        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_value("wb_valid", 16'(wb_valid), 16'h0000);
        check_value("instr_ready", 16'(instr_ready), 16'h0001);

        for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
            if (ROWS[i].gap) begin
                gap = ($urandom % 4) + 1;
                instr_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            instr_valid <= 1'b1;
            instr       <= ROWS[i].instr;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!instr_ready && waited < WAIT_LIMIT);
            if (!instr_ready) begin
                timed_out = 1'b1;
                $display("timeout: instruction %0d was never accepted", i);
            end
        end
        instr_valid <= 1'b0;

        waited = 0;
        while (!timed_out && expected_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited >= WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("timeout: %0d writebacks never arrived", expected_q.size());
            end
        end
        repeat (4) @(posedge clk); // catch stray pulses
        check_value("stall_cycles", 16'(stall_cycles), 16'(STALLS_EXPECTED));

        $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
